//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// one architectural register or ALU word
	typedef logic [31:0] word_t;

	// index into the 32-entry integer register file
	typedef logic [4:0] reg_addr_t;

	// ALU operations that the decoder can select
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu
	} alu_op_t;

	// the all-zero word that x0 and unused results return
	localparam word_t zero_word = 32'h0000_0000;

	// major opcodes for the register-register and register-immediate ALU groups
	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

	// funct3 selects the operation within both opcode groups
	localparam logic [2:0] funct3_add_sub = 3'b000;
	localparam logic [2:0] funct3_sll = 3'b001;
	localparam logic [2:0] funct3_slt = 3'b010;
	localparam logic [2:0] funct3_sltu = 3'b011;
	localparam logic [2:0] funct3_xor = 3'b100;
	localparam logic [2:0] funct3_srl_sra = 3'b101;
	localparam logic [2:0] funct3_or = 3'b110;
	localparam logic [2:0] funct3_and = 3'b111;

	// funct7 tells ADD from SUB and SRL from SRA
	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y
);

	logic [4:0] shamt;

	// RV32I shifts use only the low five bits of the second operand
	assign shamt = b[4:0];

	always_comb begin
		y = zero_word;
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or: y = a | b;
			alu_xor: y = a ^ b;
			alu_sll: y = a << shamt;
			alu_srl: y = a >> shamt;
			alu_sra: y = $signed(a) >>> shamt;
			alu_slt: begin
				// compare results are a single bit in the LSB
				y[0] = $signed(a) < $signed(b);
			end
			alu_sltu: begin
				y[0] = a < b;
			end
			default: y = zero_word;
		endcase
	end

endmodule

`default_nettype wire

//--- inst_decode.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decode
	import cpu_pkg::*;
(
	input  word_t     inst,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output word_t     imm,
	output logic      use_imm,
	output alu_op_t   op,
	output logic      reg_we
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic is_reg;
	logic is_imm;
	logic f7_base;
	logic f7_alt;
	logic legal;
	logic is_shift;
	word_t imm_i;
	word_t shamt;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign is_reg = (opcode == opcode_op);
	assign is_imm = (opcode == opcode_op_imm);
	assign f7_base = (funct7 == funct7_base);
	assign f7_alt = (funct7 == funct7_alt);

	// the I-type immediate is sign-extended from bit 31
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	// immediate shifts carry only a five-bit shift amount in the rs2 field
	assign shamt = {27'd0, inst[24:20]};
	assign is_shift = (funct3 == funct3_sll) || (funct3 == funct3_srl_sra);

	// operation select and legality check on funct3 and funct7
	always_comb begin
		op = alu_add;
		legal = 1'b0;
		case (funct3)
			funct3_add_sub: begin
				// only the register form has a SUB, ADDI ignores the upper bits
				if (is_reg && f7_alt) begin
					op = alu_sub;
					legal = 1'b1;
				end else begin
					op = alu_add;
					legal = is_imm || f7_base;
				end
			end
			funct3_sll: begin
				op = alu_sll;
				legal = f7_base;
			end
			funct3_slt: begin
				op = alu_slt;
				legal = is_imm || f7_base;
			end
			funct3_sltu: begin
				op = alu_sltu;
				legal = is_imm || f7_base;
			end
			funct3_xor: begin
				op = alu_xor;
				legal = is_imm || f7_base;
			end
			funct3_srl_sra: begin
				// the same funct7 bit picks the arithmetic shift in both forms
				op = f7_alt ? alu_sra : alu_srl;
				legal = f7_base || f7_alt;
			end
			funct3_or: begin
				op = alu_or;
				legal = is_imm || f7_base;
			end
			funct3_and: begin
				op = alu_and;
				legal = is_imm || f7_base;
			end
		endcase
		// anything outside the two ALU opcodes becomes a bubble
		if (!is_reg && !is_imm) begin
			legal = 1'b0;
		end
	end

	// an illegal encoding reads only x0 and writes nothing
	assign reg_we = legal;
	assign use_imm = legal && is_imm;
	assign rs1 = legal ? inst[19:15] : 5'd0;
	assign rs2 = (legal && is_reg) ? inst[24:20] : 5'd0;
	assign rd = inst[11:7];
	assign imm = is_shift ? shamt : imm_i;

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      aresetn,
	// write port 1, older slot of the write-back pair
	input  logic      we1,
	input  reg_addr_t waddr1,
	input  word_t     wdata1,
	// write port 2, younger slot of the write-back pair
	input  logic      we2,
	input  reg_addr_t waddr2,
	input  word_t     wdata2,
	// write port 3, late load data
	input  logic      we3,
	input  reg_addr_t waddr3,
	input  word_t     wdata3,
	// slot 1 sources on ports 1 and 2, slot 2 sources on ports 3 and 4
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	input  reg_addr_t raddr3,
	input  reg_addr_t raddr4,
	output word_t     rdata1,
	output word_t     rdata2,
	output word_t     rdata3,
	output word_t     rdata4
);

	// entry 0 is never written and never read
	word_t regs [0:31];

	// bypass lookup shared by all four read ports
	// the younger slot wins over the older one and both win over the load
	function automatic word_t bypass_read(input reg_addr_t raddr);
		word_t value;
		if (!aresetn || raddr == 5'd0) begin
			value = zero_word;
		end else if (we2 && waddr2 == raddr) begin
			value = wdata2;
		end else if (we1 && waddr1 == raddr) begin
			value = wdata1;
		end else if (we3 && waddr3 == raddr) begin
			value = wdata3;
		end else begin
			value = regs[raddr];
		end
		return value;
	endfunction

	// the last nonblocking assignment to an entry takes effect
	// so the statement order below sets the write priority port 2, port 1, port 3
	always_ff @(posedge clk) begin
		if (we3 && waddr3 != 5'd0) begin
			regs[waddr3] <= wdata3;
		end
		if (we1 && waddr1 != 5'd0) begin
			regs[waddr1] <= wdata1;
		end
		if (we2 && waddr2 != 5'd0) begin
			regs[waddr2] <= wdata2;
		end
	end

	// a write is visible to every read port in the cycle it happens
	always_comb begin
		rdata1 = bypass_read(raddr1);
	end

	always_comb begin
		rdata2 = bypass_read(raddr2);
	end

	always_comb begin
		rdata3 = bypass_read(raddr3);
	end

	always_comb begin
		rdata4 = bypass_read(raddr4);
	end

endmodule

`default_nettype wire

//--- dual_execute.sv
`timescale 1ns/1ns
`default_nettype none

module dual_execute
	import cpu_pkg::*;
(
	input  word_t     rdata1,
	input  word_t     rdata2,
	input  word_t     rdata3,
	input  word_t     rdata4,
	input  word_t     imm1,
	input  word_t     imm2,
	input  logic      use_imm1,
	input  logic      use_imm2,
	input  alu_op_t   op1,
	input  alu_op_t   op2,
	input  reg_addr_t rs1_2,
	input  reg_addr_t rs2_2,
	input  reg_addr_t rd1,
	input  logic      we1,
	output word_t     result1,
	output word_t     result2
);

	word_t a1;
	word_t b1;
	word_t a2;
	word_t b2;
	logic fwd_a2;
	logic fwd_b2;

	// slot 1 reads the register file directly
	assign a1 = rdata1;
	assign b1 = use_imm1 ? imm1 : rdata2;

	// slot 2 depends on slot 1 when slot 1 really writes a nonzero register it reads
	// a write to x0 is dropped, so x0 is never forwarded
	assign fwd_a2 = we1 && (rd1 != 5'd0) && (rd1 == rs1_2);
	assign fwd_b2 = we1 && (rd1 != 5'd0) && (rd1 == rs2_2);

	// the forward replaces the register file value, which is still the old one
	assign a2 = fwd_a2 ? result1 : rdata3;
	// the immediate takes precedence, rs2_2 is x0 for immediate forms anyway
	assign b2 = use_imm2 ? imm2 : (fwd_b2 ? result1 : rdata4);

	alu alu_1_i (
		.op (op1),
		.a  (a1),
		.b  (b1),
		.y  (result1)
	);

	// slot 2 ALU sits behind slot 1 in the same cycle
	alu alu_2_i (
		.op (op2),
		.a  (a2),
		.b  (b2),
		.y  (result2)
	);

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      aresetn,
	input  logic      valid1,
	input  logic      valid2,
	input  reg_addr_t rd1,
	input  reg_addr_t rd2,
	input  word_t     result1,
	input  word_t     result2,
	output logic      wb_valid1,
	output logic      wb_valid2,
	output reg_addr_t wb_rd1,
	output reg_addr_t wb_rd2,
	output word_t     wb_data1,
	output word_t     wb_data2
);

	// slot valid bits, taken fresh every cycle since nothing stalls
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wb_valid1 <= 1'b0;
			wb_valid2 <= 1'b0;
		end else begin
			wb_valid1 <= valid1;
			wb_valid2 <= valid2;
		end
	end

	// destination and result only move when their slot carries a write
	always_ff @(posedge clk) begin
		if (valid1) begin
			wb_rd1 <= rd1;
			wb_data1 <= result1;
		end
		if (valid2) begin
			wb_rd2 <= rd2;
			wb_data2 <= result2;
		end
	end

endmodule

`default_nettype wire

//--- dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      aresetn,
	// issue pair, slot 1 is the older instruction
	input  logic      issue_valid1,
	input  word_t     issue_inst1,
	input  logic      issue_valid2,
	input  word_t     issue_inst2,
	// load return through write port 3
	input  logic      ld_we,
	input  reg_addr_t ld_rd,
	input  word_t     ld_data,
	// committed results, also the write port 1 and 2 traffic
	output logic      wb_valid1,
	output reg_addr_t wb_rd1,
	output word_t     wb_data1,
	output logic      wb_valid2,
	output reg_addr_t wb_rd2,
	output word_t     wb_data2
);

	reg_addr_t slot1_rs1;
	reg_addr_t slot1_rs2;
	reg_addr_t slot1_rd;
	word_t slot1_imm;
	logic slot1_use_imm;
	alu_op_t slot1_op;
	logic slot1_reg_we;
	reg_addr_t slot2_rs1;
	reg_addr_t slot2_rs2;
	reg_addr_t slot2_rd;
	word_t slot2_imm;
	logic slot2_use_imm;
	alu_op_t slot2_op;
	logic slot2_reg_we;
	logic slot1_valid;
	logic slot2_valid;
	word_t rdata1;
	word_t rdata2;
	word_t rdata3;
	word_t rdata4;
	word_t result1;
	word_t result2;

	inst_decode decode_1_i (
		.inst    (issue_inst1),
		.rs1     (slot1_rs1),
		.rs2     (slot1_rs2),
		.rd      (slot1_rd),
		.imm     (slot1_imm),
		.use_imm (slot1_use_imm),
		.op      (slot1_op),
		.reg_we  (slot1_reg_we)
	);

	inst_decode decode_2_i (
		.inst    (issue_inst2),
		.rs1     (slot2_rs1),
		.rs2     (slot2_rs2),
		.rd      (slot2_rd),
		.imm     (slot2_imm),
		.use_imm (slot2_use_imm),
		.op      (slot2_op),
		.reg_we  (slot2_reg_we)
	);

	// a slot writes only if it was issued and decoded to a legal ALU op
	assign slot1_valid = issue_valid1 & slot1_reg_we;
	assign slot2_valid = issue_valid2 & slot2_reg_we;

	regfile regfile_i (
		.clk     (clk),
		.aresetn (aresetn),
		.we1     (wb_valid1),
		.waddr1  (wb_rd1),
		.wdata1  (wb_data1),
		.we2     (wb_valid2),
		.waddr2  (wb_rd2),
		.wdata2  (wb_data2),
		.we3     (ld_we),
		.waddr3  (ld_rd),
		.wdata3  (ld_data),
		.raddr1  (slot1_rs1),
		.raddr2  (slot1_rs2),
		.raddr3  (slot2_rs1),
		.raddr4  (slot2_rs2),
		.rdata1  (rdata1),
		.rdata2  (rdata2),
		.rdata3  (rdata3),
		.rdata4  (rdata4)
	);

	// an unissued slot 1 must not forward into slot 2
	dual_execute dual_execute_i (
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.rdata3   (rdata3),
		.rdata4   (rdata4),
		.imm1     (slot1_imm),
		.imm2     (slot2_imm),
		.use_imm1 (slot1_use_imm),
		.use_imm2 (slot2_use_imm),
		.op1      (slot1_op),
		.op2      (slot2_op),
		.rs1_2    (slot2_rs1),
		.rs2_2    (slot2_rs2),
		.rd1      (slot1_rd),
		.we1      (slot1_valid),
		.result1  (result1),
		.result2  (result2)
	);

	writeback_stage writeback_stage_i (
		.clk       (clk),
		.aresetn   (aresetn),
		.valid1    (slot1_valid),
		.valid2    (slot2_valid),
		.rd1       (slot1_rd),
		.rd2       (slot2_rd),
		.result1   (result1),
		.result2   (result2),
		.wb_valid1 (wb_valid1),
		.wb_valid2 (wb_valid2),
		.wb_rd1    (wb_rd1),
		.wb_rd2    (wb_rd2),
		.wb_data1  (wb_data1),
		.wb_data2  (wb_data2)
	);

endmodule

`default_nettype wire

//--- tb_dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dual_issue_core;

	localparam int clk_period = 40;
	localparam int drive_delay = 2;
	localparam int reset_cycles = 4;
	localparam int init_cycles = 32;
	localparam int directed_cycles = 8;
	localparam int random_cycles = 300;
	localparam int total_cycles = reset_cycles + init_cycles + directed_cycles + random_cycles;

	// operation indices of the reference model, not the DUT encoding
	localparam int op_add = 0;
	localparam int op_sub = 1;
	localparam int op_and = 2;
	localparam int op_or = 3;
	localparam int op_xor = 4;
	localparam int op_sll = 5;
	localparam int op_srl = 6;
	localparam int op_sra = 7;
	localparam int op_slt = 8;
	localparam int op_sltu = 9;

	logic clk;
	logic aresetn;
	logic issue_valid1;
	logic [31:0] issue_inst1;
	logic issue_valid2;
	logic [31:0] issue_inst2;
	logic ld_we;
	logic [4:0] ld_rd;
	logic [31:0] ld_data;
	logic wb_valid1;
	logic [4:0] wb_rd1;
	logic [31:0] wb_data1;
	logic wb_valid2;
	logic [4:0] wb_rd2;
	logic [31:0] wb_data2;

	// fields of the pair being issued, index 1 is the older slot
	logic s_valid [1:2];
	logic s_illegal [1:2];
	logic s_imm_form [1:2];
	int s_op [1:2];
	logic [4:0] s_rd [1:2];
	logic [4:0] s_rs1 [1:2];
	logic [4:0] s_rs2 [1:2];
	logic [11:0] s_imm [1:2];
	logic [31:0] s_inst [1:2];

	// model state, predictions for the next cycle and the pair now in write-back
	logic [31:0] model_regs [0:31];
	logic exp_valid [1:2];
	logic [4:0] exp_rd [1:2];
	logic [31:0] exp_data [1:2];
	logic pend_valid [1:2];
	logic [4:0] pend_rd [1:2];
	logic [31:0] pend_data [1:2];

	logic [31:0] rand_state;
	int errors;
	int checks;

	dual_issue_core dual_issue_core_i (
		.clk          (clk),
		.aresetn      (aresetn),
		.issue_valid1 (issue_valid1),
		.issue_inst1  (issue_inst1),
		.issue_valid2 (issue_valid2),
		.issue_inst2  (issue_inst2),
		.ld_we        (ld_we),
		.ld_rd        (ld_rd),
		.ld_data      (ld_data),
		.wb_valid1    (wb_valid1),
		.wb_rd1       (wb_rd1),
		.wb_data1     (wb_data1),
		.wb_valid2    (wb_valid2),
		.wb_rd2       (wb_rd2),
		.wb_data2     (wb_data2)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// the run has a known length, so anything past it plus a margin is a hang
	initial begin
		#(total_cycles * clk_period + 10 * clk_period);
		$display("timeout: the test sequence did not finish within the expected time");
		$display("Something failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rand_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rand_state = x;
		return x;
	endfunction

	// half the picks come from x0 to x7 so that pairs often depend on each other
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = next_rand();
		if (r[8]) begin
			return {2'b00, r[2:0]};
		end
		return r[4:0];
	endfunction

	// a load opcode or an R-type with the M-extension funct7, both unsupported
	function automatic logic [31:0] illegal_inst();
		logic [31:0] r;
		r = next_rand();
		if (r[31]) begin
			return {r[31:7], 7'b0000011};
		end
		return {7'b0000001, r[17:0], 7'b0110011};
	endfunction

	// builds the RV32I encoding from the slot fields
	function automatic logic [31:0] encode_slot(input int k);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		case (s_op[k])
			op_add, op_sub: f3 = 3'b000;
			op_and: f3 = 3'b111;
			op_or: f3 = 3'b110;
			op_xor: f3 = 3'b100;
			op_sll: f3 = 3'b001;
			op_srl, op_sra: f3 = 3'b101;
			op_slt: f3 = 3'b010;
			default: f3 = 3'b011;
		endcase
		f7 = (s_op[k] == op_sub || s_op[k] == op_sra) ? 7'b0100000 : 7'b0000000;
		if (s_imm_form[k]) begin
			// immediate shifts put funct7 in the upper immediate bits
			if (s_op[k] >= op_sll && s_op[k] <= op_sra) begin
				imm = {f7, s_imm[k][4:0]};
			end else begin
				imm = s_imm[k];
			end
			return {imm, s_rs1[k], f3, s_rd[k], 7'b0010011};
		end
		return {f7, s_rs2[k], s_rs1[k], f3, s_rd[k], 7'b0110011};
	endfunction

	// RV32I semantics of the ten operations
	function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_sll: return a << b[4:0];
			op_srl: return a >> b[4:0];
			op_sra: return $unsigned($signed(a) >>> b[4:0]);
			op_slt: return {31'd0, $signed(a) < $signed(b)};
			default: return {31'd0, a < b};
		endcase
	endfunction

	// slot 2 sees the new value of a register that slot 1 writes in the same pair
	function automatic logic [31:0] read_operand(input int k, input logic [4:0] rs);
		if (k == 2 && exp_valid[1] && exp_rd[1] != 5'd0 && exp_rd[1] == rs) begin
			return exp_data[1];
		end
		return model_regs[rs];
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic set_slot(input int k, input logic valid, input logic illegal, input int op,
			input logic imm_form, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [11:0] imm);
		s_valid[k] = valid;
		s_illegal[k] = illegal;
		s_op[k] = op;
		s_imm_form[k] = imm_form;
		s_rd[k] = rd;
		s_rs1[k] = rs1;
		s_rs2[k] = rs2;
		s_imm[k] = imm;
		s_inst[k] = illegal ? illegal_inst() : encode_slot(k);
	endtask

	task automatic set_load(input logic we, input logic [4:0] rd, input logic [31:0] data);
		ld_we = we;
		ld_rd = rd;
		ld_data = data;
	endtask

	task automatic random_slot(input int k);
		logic [31:0] r;
		r = next_rand();
		s_valid[k] = r[3:0] != 4'd0;
		s_illegal[k] = r[7:4] == 4'd0;
		s_imm_form[k] = r[8];
		s_op[k] = int'(next_rand() % 32'd10);
		// there is no SUBI in RV32I
		if (s_imm_form[k] && s_op[k] == op_sub) begin
			s_imm_form[k] = 1'b0;
		end
		s_rd[k] = pick_reg();
		s_rs1[k] = pick_reg();
		s_rs2[k] = pick_reg();
		s_imm[k] = r[31:20];
		s_inst[k] = s_illegal[k] ? illegal_inst() : encode_slot(k);
	endtask

	task automatic random_load();
		logic [31:0] r;
		r = next_rand();
		// a load returns in about a quarter of the cycles
		set_load(r[1:0] == 2'b00, pick_reg(), next_rand());
	endtask

	// load first, then the older and the younger write-back, so the last write wins
	task automatic predict_pair();
		logic [31:0] a;
		logic [31:0] b;
		if (ld_we && ld_rd != 5'd0) begin
			model_regs[ld_rd] = ld_data;
		end
		for (int k = 1; k <= 2; k++) begin
			if (pend_valid[k] && pend_rd[k] != 5'd0) begin
				model_regs[pend_rd[k]] = pend_data[k];
			end
		end
		for (int k = 1; k <= 2; k++) begin
			exp_valid[k] = s_valid[k] && !s_illegal[k];
			exp_rd[k] = s_rd[k];
			a = read_operand(k, s_rs1[k]);
			if (!s_imm_form[k]) begin
				b = read_operand(k, s_rs2[k]);
			end else if (s_op[k] >= op_sll && s_op[k] <= op_sra) begin
				b = {27'd0, s_imm[k][4:0]};
			end else begin
				b = {{20{s_imm[k][11]}}, s_imm[k]};
			end
			exp_data[k] = alu_model(s_op[k], a, b);
		end
	endtask

	// one issue cycle with a fixed write-back latency of one
	task automatic run_cycle();
		predict_pair();
		issue_valid1 = s_valid[1];
		issue_inst1 = s_inst[1];
		issue_valid2 = s_valid[2];
		issue_inst2 = s_inst[2];
		@(posedge clk);
		#drive_delay;
		check_value("wb_valid1", {31'd0, wb_valid1}, {31'd0, exp_valid[1]});
		check_value("wb_valid2", {31'd0, wb_valid2}, {31'd0, exp_valid[2]});
		if (exp_valid[1]) begin
			check_value("wb_rd1", {27'd0, wb_rd1}, {27'd0, exp_rd[1]});
			check_value("wb_data1", wb_data1, exp_data[1]);
		end
		if (exp_valid[2]) begin
			check_value("wb_rd2", {27'd0, wb_rd2}, {27'd0, exp_rd[2]});
			check_value("wb_data2", wb_data2, exp_data[2]);
		end
		for (int k = 1; k <= 2; k++) begin
			pend_valid[k] = exp_valid[k];
			pend_rd[k] = exp_rd[k];
			pend_data[k] = exp_data[k];
			s_valid[k] = 1'b0;
			s_illegal[k] = 1'b0;
		end
		set_load(1'b0, 5'd0, 32'd0);
	endtask

	initial begin
		aresetn = 1'b0;
		// ADDI x1 and ADDI x2 wait on the issue port through reset
		// and only the reset keeps them out of write-back
		issue_valid1 = 1'b1;
		issue_inst1 = 32'h0010_0093;
		issue_valid2 = 1'b1;
		issue_inst2 = 32'h0020_0113;
		set_load(1'b0, 5'd0, 32'd0);
		rand_state = 32'he914_7aff;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = 32'd0;
		end
		for (int k = 1; k <= 2; k++) begin
			pend_valid[k] = 1'b0;
			s_valid[k] = 1'b0;
			s_illegal[k] = 1'b0;
		end

		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		// nothing is in write-back straight after reset
		check_value("wb_valid1 after reset", {31'd0, wb_valid1}, 32'd0);
		check_value("wb_valid2 after reset", {31'd0, wb_valid2}, 32'd0);
		aresetn = 1'b1;

		// every register is loaded once, then read back by ADDI rd, rd, 0 a cycle later
		for (int i = 1; i <= init_cycles; i++) begin
			set_load(i < 32, 5'(i), next_rand());
			if (i >= 2) begin
				set_slot(1, 1'b1, 1'b0, op_add, 1'b1, 5'(i - 1), 5'(i - 1), 5'd0, 12'd0);
			end
			run_cycle();
		end

		// cascade into rs1 and into rs2 of slot 2
		set_slot(1, 1'b1, 1'b0, op_add, 1'b1, 5'd3, 5'd1, 5'd0, 12'd100);
		set_slot(2, 1'b1, 1'b0, op_add, 1'b0, 5'd4, 5'd3, 5'd3, 12'd0);
		run_cycle();
		set_slot(1, 1'b1, 1'b0, op_xor, 1'b0, 5'd10, 5'd1, 5'd2, 12'd0);
		set_slot(2, 1'b1, 1'b0, op_sub, 1'b0, 5'd11, 5'd2, 5'd10, 12'd0);
		run_cycle();
		// both slots hit x5 and the younger slot must win
		set_slot(1, 1'b1, 1'b0, op_add, 1'b1, 5'd5, 5'd0, 5'd0, 12'd1);
		set_slot(2, 1'b1, 1'b0, op_add, 1'b1, 5'd5, 5'd0, 5'd0, 12'd2);
		run_cycle();
		// a load to x5 meets both write-back writes of x5 in the same cycle
		set_load(1'b1, 5'd5, next_rand());
		set_slot(1, 1'b1, 1'b0, op_add, 1'b1, 5'd6, 5'd5, 5'd0, 12'd0);
		set_slot(2, 1'b1, 1'b0, op_add, 1'b0, 5'd8, 5'd5, 5'd5, 12'd0);
		run_cycle();
		// x5 comes from storage, x6 through the write-back bypass
		// and x7 through the load bypass
		set_load(1'b1, 5'd7, next_rand());
		set_slot(1, 1'b1, 1'b0, op_add, 1'b1, 5'd5, 5'd5, 5'd0, 12'd0);
		set_slot(2, 1'b1, 1'b0, op_add, 1'b0, 5'd8, 5'd7, 5'd6, 12'd0);
		run_cycle();
		// a write to x0 is dropped and must not be forwarded
		set_slot(1, 1'b1, 1'b0, op_add, 1'b1, 5'd0, 5'd0, 5'd0, 12'h055);
		set_slot(2, 1'b1, 1'b0, op_add, 1'b0, 5'd9, 5'd0, 5'd0, 12'd0);
		run_cycle();
		set_slot(1, 1'b1, 1'b0, op_or, 1'b1, 5'd12, 5'd0, 5'd0, 12'd0);
		set_slot(2, 1'b1, 1'b1, op_add, 1'b0, 5'd13, 5'd0, 5'd0, 12'd0);
		run_cycle();
		// an unissued slot 1 leaves slot 2 with the register file value
		set_slot(1, 1'b0, 1'b0, op_add, 1'b1, 5'd13, 5'd0, 5'd0, 12'h7ff);
		set_slot(2, 1'b1, 1'b0, op_add, 1'b0, 5'd14, 5'd13, 5'd13, 12'd0);
		run_cycle();

		for (int i = 0; i < random_cycles; i++) begin
			random_slot(1);
			random_slot(2);
			random_load();
			run_cycle();
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
cpu_pkg.sv
alu.sv
inst_decode.sv
regfile.sv
dual_execute.sv
writeback_stage.sv
dual_issue_core.sv
tb_dual_issue_core.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the run passes only when the pass line shows up in the simulation output
verilator --binary --timing --top-module tb_dual_issue_core -f build.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
